/* cl_manycore_pkg.sv */
`default_nettype none

package cl_manycore_pkg;

  // ------------------------------
  // Geometry and limits
  // ------------------------------
  localparam int num_tiles_lp       = 4;
  localparam int tile_words_lp      = 64;
  localparam int max_out_credits_lp = 4;

  // Decoded window starts at address 0
  localparam int axil_window_bytes_lp = num_tiles_lp * tile_words_lp * 4;

  // ------------------------------
  // Vector types
  // ------------------------------
  typedef logic [31:0] axil_addr_t;
  typedef logic [31:0] data_t;
  typedef logic [3:0]  strb_t;
  typedef logic [1:0]  axil_resp_t;

  // Address bits 9..8 select the tile, bits 7..2 the word
  typedef logic [1:0]  tile_idx_t;
  typedef logic [5:0]  word_idx_t;

  // Wide enough to hold max_out_credits_lp
  typedef logic [2:0]  credit_t;

  // AXI-Lite response codes
  localparam axil_resp_t resp_okay_lp   = 2'b00;
  localparam axil_resp_t resp_slverr_lp = 2'b10;

  // ------------------------------
  // Buses
  // ------------------------------
  // Broadcast request from the bridge, 43 bits
  typedef struct packed {
    logic      write;
    word_idx_t word_idx;
    data_t     data;
    strb_t     strb;
  } tile_req_s;

  // Held tile response, 33 bits
  typedef struct packed {
    logic  read;
    data_t data;
  } tile_rsp_s;

  // Collector completion, 34 bits
  typedef struct packed {
    logic  valid;
    logic  read;
    data_t data;
  } done_s;

  // Bridge read FSM
  typedef enum logic [1:0] {
    RD_IDLE,
    RD_WAIT,
    RD_RESP
  } rd_state_e;

endpackage

`default_nettype wire

/* host_link_bridge.sv */
`default_nettype none

module host_link_bridge
  import cl_manycore_pkg::*;
(
  input  wire                     clk_main_a0,
  input  wire                     rst_main_n_sync,

  // AXI-Lite write address and data
  input  wire                     awvalid_i,
  input  axil_addr_t              awaddr_i,
  output logic                    awready_o,
  input  wire                     wvalid_i,
  input  data_t                   wdata_i,
  input  strb_t                   wstrb_i,
  output logic                    wready_o,

  // AXI-Lite write response
  output logic                    bvalid_o,
  output axil_resp_t              bresp_o,
  input  wire                     bready_i,

  // AXI-Lite read address and data
  input  wire                     arvalid_i,
  input  axil_addr_t              araddr_i,
  output logic                    arready_o,
  output logic                    rvalid_o,
  output data_t                   rdata_o,
  output axil_resp_t              rresp_o,
  input  wire                     rready_i,

  // Tile side
  output tile_req_s               tile_req_o,
  output logic [num_tiles_lp-1:0] tile_req_valid_o,
  input  wire  [num_tiles_lp-1:0] tile_req_ready_i,
  input  done_s                   done_i
);

  // ------------------------------
  // Address decode
  // ------------------------------
  logic      aw_in_range;
  tile_idx_t aw_tile;
  word_idx_t aw_word;
  logic      ar_in_range;
  tile_idx_t ar_tile;
  word_idx_t ar_word;

  assign aw_in_range = (awaddr_i < axil_addr_t'(axil_window_bytes_lp));
  assign aw_tile     = awaddr_i[9:8];
  assign aw_word     = awaddr_i[7:2];

  assign ar_in_range = (araddr_i < axil_addr_t'(axil_window_bytes_lp));
  assign ar_tile     = araddr_i[9:8];
  assign ar_word     = araddr_i[7:2];

  // ------------------------------
  // Accept logic
  // ------------------------------
  credit_t   credits_q;
  rd_state_e rd_state_q;
  logic      bvalid_q;
  logic      credit_free;
  logic      wr_fire_tile;
  logic      wr_fire_oor;
  logic      rd_fire_tile;
  logic      rd_fire_oor;
  logic      req_issue;

  assign credit_free = (credits_q != '0);

  // Both halves of a write must be present
  assign wr_fire_tile = awvalid_i & wvalid_i & ~bvalid_q & aw_in_range
                      & credit_free & tile_req_ready_i[aw_tile];
  assign wr_fire_oor  = awvalid_i & wvalid_i & ~bvalid_q & ~aw_in_range;

  // Writes win the shared request bus
  assign rd_fire_tile = arvalid_i & (rd_state_q == RD_IDLE) & ar_in_range
                      & credit_free & tile_req_ready_i[ar_tile] & ~wr_fire_tile;
  assign rd_fire_oor  = arvalid_i & (rd_state_q == RD_IDLE) & ~ar_in_range;

  assign req_issue = wr_fire_tile | rd_fire_tile;

  assign awready_o = wr_fire_tile | wr_fire_oor;
  assign wready_o  = wr_fire_tile | wr_fire_oor;
  assign arready_o = rd_fire_tile | rd_fire_oor;

  // ------------------------------
  // Tile request
  // ------------------------------
  always_comb begin
    tile_req_o.write    = wr_fire_tile;
    tile_req_o.word_idx = wr_fire_tile ? aw_word : ar_word;
    tile_req_o.data     = wdata_i;
    tile_req_o.strb     = wstrb_i;

    tile_req_valid_o = '0;
    if (wr_fire_tile) begin
      tile_req_valid_o[aw_tile] = 1'b1;
    end else if (rd_fire_tile) begin
      tile_req_valid_o[ar_tile] = 1'b1;
    end
  end

  // Credit goes back on completion, not on the B handshake
  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      credits_q <= credit_t'(max_out_credits_lp);
    end else begin
      credits_q <= credits_q - credit_t'(req_issue) + credit_t'(done_i.valid);
    end
  end

  // ------------------------------
  // Write response
  // ------------------------------
  axil_resp_t bresp_q;

  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      bvalid_q <= 1'b0;
    end else if (wr_fire_tile || wr_fire_oor) begin
      bvalid_q <= 1'b1;
    end else if (bready_i) begin
      bvalid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_main_a0) begin
    if (wr_fire_tile || wr_fire_oor) begin
      bresp_q <= aw_in_range ? resp_okay_lp : resp_slverr_lp;
    end
  end

  assign bvalid_o = bvalid_q;
  assign bresp_o  = bresp_q;

  // ------------------------------
  // Read FSM
  // ------------------------------
  data_t      rdata_q;
  axil_resp_t rresp_q;

  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      rd_state_q <= RD_IDLE;
    end else begin
      unique case (rd_state_q)
        RD_IDLE: begin
          if (rd_fire_oor) begin
            rd_state_q <= RD_RESP;
          end else if (rd_fire_tile) begin
            rd_state_q <= RD_WAIT;
          end
        end
        RD_WAIT: begin
          if (done_i.valid && done_i.read) begin
            rd_state_q <= RD_RESP;
          end
        end
        RD_RESP: begin
          if (rready_i) begin
            rd_state_q <= RD_IDLE;
          end
        end
        default: rd_state_q <= RD_IDLE;
      endcase
    end
  end

  // Out-of-range reads return zero data
  always_ff @(posedge clk_main_a0) begin
    if (rd_fire_oor) begin
      rdata_q <= '0;
      rresp_q <= resp_slverr_lp;
    end else if ((rd_state_q == RD_WAIT) && done_i.valid && done_i.read) begin
      rdata_q <= done_i.data;
      rresp_q <= resp_okay_lp;
    end
  end

  assign rvalid_o = (rd_state_q == RD_RESP);
  assign rdata_o  = rdata_q;
  assign rresp_o  = rresp_q;

endmodule

`default_nettype wire

/* dmem_tile.sv */
`default_nettype none

module dmem_tile
  import cl_manycore_pkg::*;
(
  input  wire       clk_main_a0,
  input  wire       rst_main_n_sync,

  // Request from the bridge
  input  tile_req_s req_i,
  input  wire       req_valid_i,
  output logic      req_ready_o,

  // Held response toward the collector
  output tile_rsp_s rsp_o,
  output logic      rsp_valid_o,
  input  wire       rsp_pop_i
);

  // ------------------------------
  // Storage
  // ------------------------------
  data_t mem_q [tile_words_lp];

  logic      req_fire;
  data_t     old_word;
  data_t     merged_word;
  logic      rsp_valid_q;
  tile_rsp_s rsp_q;

  // Slot frees up in the same cycle it is popped
  assign req_ready_o = ~rsp_valid_q | rsp_pop_i;
  assign req_fire    = req_valid_i & req_ready_o;

  assign old_word = mem_q[req_i.word_idx];

  // Byte merge under the strobe
  always_comb begin
    merged_word = old_word;
    for (int b = 0; b < $bits(strb_t); b++) begin
      if (req_i.strb[b]) begin
        merged_word[8*b +: 8] = req_i.data[8*b +: 8];
      end
    end
  end

  always_ff @(posedge clk_main_a0) begin
    if (req_fire && req_i.write) begin
      mem_q[req_i.word_idx] <= merged_word;
    end
  end

  // ------------------------------
  // Response slot
  // ------------------------------
  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      rsp_valid_q <= 1'b0;
    end else if (req_fire) begin
      rsp_valid_q <= 1'b1;
    end else if (rsp_pop_i) begin
      rsp_valid_q <= 1'b0;
    end
  end

  // Writes echo the stored word back
  always_ff @(posedge clk_main_a0) begin
    if (req_fire) begin
      rsp_q.read <= ~req_i.write;
      rsp_q.data <= req_i.write ? merged_word : old_word;
    end
  end

  assign rsp_valid_o = rsp_valid_q;
  assign rsp_o       = rsp_q;

endmodule

`default_nettype wire

/* resp_collector.sv */
`default_nettype none

module resp_collector
  import cl_manycore_pkg::*;
(
  input  wire                               clk_main_a0,
  input  wire                               rst_main_n_sync,

  // Tile responses
  input  tile_rsp_s [num_tiles_lp-1:0]      rsp_i,
  input  wire       [num_tiles_lp-1:0]      rsp_valid_i,
  output logic      [num_tiles_lp-1:0]      rsp_pop_o,

  // Completion toward the bridge
  output done_s                             done_o
);

  // ------------------------------
  // Round-robin pick
  // ------------------------------
  tile_idx_t last_grant_q;
  tile_idx_t grant_idx;
  logic      grant_any;

  // Search starts one past the last grant and wraps back to it
  always_comb begin
    tile_idx_t cand;

    grant_any = 1'b0;
    grant_idx = last_grant_q;
    cand      = last_grant_q;
    for (int i = 1; i <= num_tiles_lp; i++) begin
      cand = tile_idx_t'(last_grant_q + tile_idx_t'(i));
      if (!grant_any && rsp_valid_i[cand]) begin
        grant_any = 1'b1;
        grant_idx = cand;
      end
    end
  end

  always_comb begin
    rsp_pop_o = '0;
    rsp_pop_o[grant_idx] = grant_any;
  end

  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      last_grant_q <= tile_idx_t'(num_tiles_lp - 1);
    end else if (grant_any) begin
      last_grant_q <= grant_idx;
    end
  end

  // ------------------------------
  // Completion register
  // ------------------------------
  logic  done_valid_q;
  logic  done_read_q;
  data_t done_data_q;

  // Single-cycle pulse per grant
  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      done_valid_q <= 1'b0;
    end else begin
      done_valid_q <= grant_any;
    end
  end

  always_ff @(posedge clk_main_a0) begin
    if (grant_any) begin
      done_read_q <= rsp_i[grant_idx].read;
      done_data_q <= rsp_i[grant_idx].data;
    end
  end

  assign done_o.valid = done_valid_q;
  assign done_o.read  = done_read_q;
  assign done_o.data  = done_data_q;

endmodule

`default_nettype wire

/* cl_manycore.sv */
`default_nettype none

module cl_manycore
  import cl_manycore_pkg::*;
(
  input  wire        clk_main_a0,
  input  wire        rst_main_n_sync,

  input  wire        awvalid_i,
  input  axil_addr_t awaddr_i,
  output logic       awready_o,
  input  wire        wvalid_i,
  input  data_t      wdata_i,
  input  strb_t      wstrb_i,
  output logic       wready_o,
  output logic       bvalid_o,
  output axil_resp_t bresp_o,
  input  wire        bready_i,
  input  wire        arvalid_i,
  input  axil_addr_t araddr_i,
  output logic       arready_o,
  output logic       rvalid_o,
  output data_t      rdata_o,
  output axil_resp_t rresp_o,
  input  wire        rready_i
);

  // ------------------------------
  // Interconnect
  // ------------------------------
  tile_req_s                    tile_req;
  logic      [num_tiles_lp-1:0] tile_req_valid;
  logic      [num_tiles_lp-1:0] tile_req_ready;
  tile_rsp_s [num_tiles_lp-1:0] tile_rsp;
  logic      [num_tiles_lp-1:0] tile_rsp_valid;
  logic      [num_tiles_lp-1:0] tile_rsp_pop;
  done_s                        done;

  host_link_bridge u_bridge (
    .clk_main_a0      (clk_main_a0),
    .rst_main_n_sync  (rst_main_n_sync),
    .awvalid_i        (awvalid_i),
    .awaddr_i         (awaddr_i),
    .awready_o        (awready_o),
    .wvalid_i         (wvalid_i),
    .wdata_i          (wdata_i),
    .wstrb_i          (wstrb_i),
    .wready_o         (wready_o),
    .bvalid_o         (bvalid_o),
    .bresp_o          (bresp_o),
    .bready_i         (bready_i),
    .arvalid_i        (arvalid_i),
    .araddr_i         (araddr_i),
    .arready_o        (arready_o),
    .rvalid_o         (rvalid_o),
    .rdata_o          (rdata_o),
    .rresp_o          (rresp_o),
    .rready_i         (rready_i),
    .tile_req_o       (tile_req),
    .tile_req_valid_o (tile_req_valid),
    .tile_req_ready_i (tile_req_ready),
    .done_i           (done)
  );

  // One memory tile per index, all on the broadcast request
  for (genvar i = 0; i < num_tiles_lp; i++) begin : g_tile
    dmem_tile u_tile (
      .clk_main_a0     (clk_main_a0),
      .rst_main_n_sync (rst_main_n_sync),
      .req_i           (tile_req),
      .req_valid_i     (tile_req_valid[i]),
      .req_ready_o     (tile_req_ready[i]),
      .rsp_o           (tile_rsp[i]),
      .rsp_valid_o     (tile_rsp_valid[i]),
      .rsp_pop_i       (tile_rsp_pop[i])
    );
  end

  resp_collector u_collector (
    .clk_main_a0     (clk_main_a0),
    .rst_main_n_sync (rst_main_n_sync),
    .rsp_i           (tile_rsp),
    .rsp_valid_i     (tile_rsp_valid),
    .rsp_pop_o       (tile_rsp_pop),
    .done_o          (done)
  );

endmodule

`default_nettype wire

/* tb_cl_manycore.sv */
`default_nettype none

module tb_cl_manycore
  import cl_manycore_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int timeout_cycles = 200;

  logic       clk_main_a0;
  logic       rst_main_n_sync;
  logic       awvalid;
  axil_addr_t awaddr;
  logic       awready;
  logic       wvalid;
  data_t      wdata;
  strb_t      wstrb;
  logic       wready;
  logic       bvalid;
  axil_resp_t bresp;
  logic       bready;
  logic       arvalid;
  axil_addr_t araddr;
  logic       arready;
  logic       rvalid;
  data_t      rdata;
  axil_resp_t rresp;
  logic       rready;

  int          checks;
  int          errors;
  logic [31:0] lcg_state;
  // Host view of the whole window with one entry per word
  data_t       ref_mem [256];

  cl_manycore u_dut (
    .clk_main_a0     (clk_main_a0),
    .rst_main_n_sync (rst_main_n_sync),
    .awvalid_i       (awvalid),
    .awaddr_i        (awaddr),
    .awready_o       (awready),
    .wvalid_i        (wvalid),
    .wdata_i         (wdata),
    .wstrb_i         (wstrb),
    .wready_o        (wready),
    .bvalid_o        (bvalid),
    .bresp_o         (bresp),
    .bready_i        (bready),
    .arvalid_i       (arvalid),
    .araddr_i        (araddr),
    .arready_o       (arready),
    .rvalid_o        (rvalid),
    .rdata_o         (rdata),
    .rresp_o         (rresp),
    .rready_i        (rready)
  );

  always #2 clk_main_a0 = ~clk_main_a0;

  // ------------------------------
  // Helpers
  // ------------------------------
  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic data_t strobe_merge(input data_t old_word, input data_t new_word,
                                         input strb_t strb);
    data_t mask;
    mask = {{8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}};
    return (old_word & ~mask) | (new_word & mask);
  endfunction

  function automatic logic in_window(input axil_addr_t addr);
    return addr < axil_addr_t'(axil_window_bytes_lp);
  endfunction

  task automatic check_bit(input string what, input logic got, input logic exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("FAILED at %0t ns: %s is %b, expected %b", $time, what, got, exp);
    end
  endtask

  task automatic check_word(input string what, input data_t got, input data_t exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("FAILED at %0t ns: %s is 0x%08h, expected 0x%08h", $time, what, got, exp);
    end
  endtask

  task automatic check_resp(input string what, input axil_resp_t got, input axil_resp_t exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("FAILED at %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
    end
  endtask

  task automatic abort_on_timeout(input string what);
    $display("Timeout at %0t ns: %s", $time, what);
    $display("Checks run: %0d, errors: %0d, timeouts: 1", checks, errors);
    $display("Simulation failed");
    $finish;
  endtask

  task automatic finish_run();
    $display("Checks run: %0d, errors: %0d, timeouts: 0", checks, errors);
    if (errors == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  endtask

  // ------------------------------
  // Handshake waits
  // ------------------------------
  task automatic wait_awready();
    int n;
    n = 0;
    @(negedge clk_main_a0);
    while (awready !== 1'b1) begin
      n++;
      if (n > timeout_cycles) begin
        abort_on_timeout("awready_o never rose");
      end
      @(negedge clk_main_a0);
    end
  endtask

  task automatic wait_bvalid();
    int n;
    n = 0;
    @(negedge clk_main_a0);
    while (bvalid !== 1'b1) begin
      n++;
      if (n > timeout_cycles) begin
        abort_on_timeout("bvalid_o never rose");
      end
      @(negedge clk_main_a0);
    end
  endtask

  task automatic wait_arready();
    int n;
    n = 0;
    @(negedge clk_main_a0);
    while (arready !== 1'b1) begin
      n++;
      if (n > timeout_cycles) begin
        abort_on_timeout("arready_o never rose");
      end
      @(negedge clk_main_a0);
    end
  endtask

  task automatic wait_rvalid();
    int n;
    n = 0;
    @(negedge clk_main_a0);
    while (rvalid !== 1'b1) begin
      n++;
      if (n > timeout_cycles) begin
        abort_on_timeout("rvalid_o never rose");
      end
      @(negedge clk_main_a0);
    end
  endtask

  // ------------------------------
  // AXI-Lite transfers
  // ------------------------------
  task automatic axil_write(input axil_addr_t addr, input data_t data, input strb_t strb,
                            output axil_resp_t resp);
    @(posedge clk_main_a0);
    awvalid <= 1'b1;
    awaddr  <= addr;
    wvalid  <= 1'b1;
    wdata   <= data;
    wstrb   <= strb;
    wait_awready();
    check_bit("wready_o with awready_o", wready, 1'b1);
    @(posedge clk_main_a0);
    awvalid <= 1'b0;
    wvalid  <= 1'b0;
    wait_bvalid();
    resp = bresp;
  endtask

  task automatic axil_read(input axil_addr_t addr, output data_t data, output axil_resp_t resp);
    @(posedge clk_main_a0);
    arvalid <= 1'b1;
    araddr  <= addr;
    wait_arready();
    @(posedge clk_main_a0);
    arvalid <= 1'b0;
    wait_rvalid();
    data = rdata;
    resp = rresp;
  endtask

  task automatic write_and_track(input axil_addr_t addr, input data_t data, input strb_t strb);
    axil_resp_t resp;
    axil_write(addr, data, strb, resp);
    if (in_window(addr)) begin
      check_resp($sformatf("bresp @0x%08h", addr), resp, resp_okay_lp);
      ref_mem[addr[9:2]] = strobe_merge(ref_mem[addr[9:2]], data, strb);
    end else begin
      check_resp($sformatf("bresp @0x%08h", addr), resp, resp_slverr_lp);
    end
  endtask

  task automatic read_and_compare(input axil_addr_t addr);
    data_t      data;
    axil_resp_t resp;
    axil_read(addr, data, resp);
    if (in_window(addr)) begin
      check_resp($sformatf("rresp @0x%08h", addr), resp, resp_okay_lp);
      check_word($sformatf("rdata @0x%08h", addr), data, ref_mem[addr[9:2]]);
    end else begin
      check_resp($sformatf("rresp @0x%08h", addr), resp, resp_slverr_lp);
      check_word($sformatf("rdata @0x%08h", addr), data, 32'h0);
    end
  endtask

  // ------------------------------
  // Directed tests
  // ------------------------------
  task automatic check_quiet(input string when);
    check_bit({"awready_o ", when}, awready, 1'b0);
    check_bit({"wready_o ", when}, wready, 1'b0);
    check_bit({"arready_o ", when}, arready, 1'b0);
    check_bit({"bvalid_o ", when}, bvalid, 1'b0);
    check_bit({"rvalid_o ", when}, rvalid, 1'b0);
  endtask

  task automatic test_reset();
    int c;
    for (c = 0; c < 5; c++) begin
      @(negedge clk_main_a0);
      check_quiet("in reset");
    end
    @(posedge clk_main_a0);
    rst_main_n_sync <= 1'b1;
    // First edge that samples the released reset
    @(posedge clk_main_a0);
    @(negedge clk_main_a0);
    check_quiet("after reset");
  endtask

  task automatic test_write_read();
    int t;
    int k;
    int words [4];
    words = '{0, 13, 42, 63};
    for (t = 0; t < num_tiles_lp; t++) begin
      for (k = 0; k < 4; k++) begin
        write_and_track(axil_addr_t'(t * 256 + words[k] * 4), lcg_next(), 4'hF);
      end
    end
    for (t = 0; t < num_tiles_lp; t++) begin
      for (k = 0; k < 4; k++) begin
        read_and_compare(axil_addr_t'(t * 256 + words[k] * 4));
      end
    end
  endtask

  task automatic test_strobes();
    axil_addr_t addr;
    data_t      data;
    axil_resp_t resp;
    addr = axil_addr_t'(2 * 256 + 7 * 4);
    write_and_track(addr, 32'hAABBCCDD, 4'hF);
    write_and_track(addr, 32'h11223344, 4'b0101);
    axil_read(addr, data, resp);
    check_resp("rresp with strobe 0101", resp, resp_okay_lp);
    check_word("byte merge with strobe 0101", data, 32'hAA22CC44);
    write_and_track(addr, lcg_next(), 4'b1000);
    read_and_compare(addr);
    // Empty strobe leaves the word alone
    write_and_track(addr, lcg_next(), 4'b0000);
    read_and_compare(addr);
  endtask

  task automatic test_out_of_range();
    write_and_track(32'h0000_0400, lcg_next(), 4'hF);
    write_and_track(32'h0000_1100, lcg_next(), 4'hF);
    write_and_track(32'hFFFF_FFFC, lcg_next(), 4'hF);
    read_and_compare(32'h0000_0400);
    read_and_compare(32'h8000_0000);
    // Words that share the low address bits with the rejected accesses
    read_and_compare(32'h0000_0000);
    read_and_compare(32'h0000_0100);
    read_and_compare(32'h0000_03FC);
  endtask

  task automatic test_backpressure();
    axil_addr_t addr_b;
    data_t      data_b;
    data_t      held_data;
    axil_resp_t held_resp;
    int         c;
    addr_b = axil_addr_t'(3 * 256 + 9 * 4);
    data_b = lcg_next();
    @(posedge clk_main_a0);
    bready <= 1'b0;
    write_and_track(axil_addr_t'(1 * 256 + 5 * 4), lcg_next(), 4'hF);
    // Second write waits behind the held B response
    @(posedge clk_main_a0);
    awvalid <= 1'b1;
    awaddr  <= addr_b;
    wvalid  <= 1'b1;
    wdata   <= data_b;
    wstrb   <= 4'hF;
    for (c = 0; c < 6; c++) begin
      @(negedge clk_main_a0);
      check_bit("bvalid_o while bready low", bvalid, 1'b1);
      check_bit("awready_o while bvalid high", awready, 1'b0);
      check_resp("bresp_o while held", bresp, resp_okay_lp);
    end
    @(posedge clk_main_a0);
    bready <= 1'b1;
    wait_awready();
    @(posedge clk_main_a0);
    awvalid <= 1'b0;
    wvalid  <= 1'b0;
    wait_bvalid();
    check_resp("bresp_o after release", bresp, resp_okay_lp);
    ref_mem[addr_b[9:2]] = data_b;

    @(posedge clk_main_a0);
    rready <= 1'b0;
    axil_read(addr_b, held_data, held_resp);
    check_word("rdata_o before hold", held_data, data_b);
    check_resp("rresp_o before hold", held_resp, resp_okay_lp);
    for (c = 0; c < 6; c++) begin
      @(negedge clk_main_a0);
      check_bit("rvalid_o while rready low", rvalid, 1'b1);
      check_word("rdata_o while held", rdata, held_data);
      check_resp("rresp_o while held", rresp, held_resp);
    end
    @(posedge clk_main_a0);
    rready <= 1'b1;
    @(posedge clk_main_a0);
    @(negedge clk_main_a0);
    check_bit("rvalid_o after release", rvalid, 1'b0);
  endtask

  task automatic test_all_tiles();
    int r;
    int t;
    for (r = 0; r < 3; r++) begin
      for (t = 0; t < num_tiles_lp; t++) begin
        write_and_track(axil_addr_t'(t * 256 + 20 * 4), lcg_next(), (r == 1) ? 4'b0011 : 4'hF);
      end
    end
    for (t = 0; t < num_tiles_lp; t++) begin
      read_and_compare(axil_addr_t'(t * 256 + 20 * 4));
    end
  endtask

  initial begin
    clk_main_a0     = 1'b0;
    checks          = 0;
    errors          = 0;
    lcg_state       = 32'h3b0a2a3b;
    rst_main_n_sync <= 1'b0;
    awvalid         <= 1'b0;
    awaddr          <= '0;
    wvalid          <= 1'b0;
    wdata           <= '0;
    wstrb           <= '0;
    bready          <= 1'b1;
    arvalid         <= 1'b0;
    araddr          <= '0;
    rready          <= 1'b1;
    test_reset();
    test_write_read();
    test_strobes();
    test_out_of_range();
    test_backpressure();
    test_all_tiles();
    finish_run();
  end

endmodule

`default_nettype wire

/* build.f */
cl_manycore_pkg.sv
host_link_bridge.sv
dmem_tile.sv
resp_collector.sv
cl_manycore.sv
tb_cl_manycore.sv

/* run.sh */
#!/usr/bin/env bash
# Build the testbench with Verilator, run it and check for the pass line
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module tb_cl_manycore -f build.f -o tb_cl_manycore

output="$(./obj_dir/tb_cl_manycore)"
echo "${output}"

if grep -qx "Simulation completed successfully" <<< "${output}"; then
  exit 0
else
  exit 1
fi
